// File: sim/cpuTrace.txt
# P addr word = program word, I value = inPort, O value = expected outPort in order
# S addr data = expected memory write in order, L cycles = timeout (decimal), others hex
L 2000
I A5A5C3C3
P 00 08801234
P 01 0907FFF8
P 02 09800004
P 03 1A090000
P 04 BA000000
P 05 22090000
P 06 BA000000
P 07 52090000
P 08 BA000000
P 09 5A090000
P 0A BA000000
P 0B 620FFFCC
P 0C BA000000
P 0D 6A080FF0
P 0E BA000000
P 0F 72100005
P 10 BA000000
P 11 2A118000
P 12 BA000000
P 13 32118000
P 14 BA000000
P 15 3A098000
P 16 BA000000
P 17 42098000
P 18 BA000000
P 19 4A118000
P 1A BA000000
P 1B 8A080000
P 1C BA000000
P 1D 92100000
P 1E BA000000
P 1F 0A8000C0
P 20 10AFFFF0
P 21 08000050
P 22 120000B4
P 23 032FFFF0
P 24 BB000000
P 25 B3800000
P 26 BB800000
P 27 98880001
P 28 B8800000
P 29 99180001
P 2A B8800000
P 2B 99000001
P 2C B9800000
P 2D 99100001
P 2E B9000000
P 2F 0C000040
P 30 AC480000
P 31 D0000000
P 32 BC800000
P 33 D8000000
P 40 BA800000
P 41 A4800000
# ALU results from add, sub, and, or, addi, andi, ori, shr, shra, shl, ror, rol, neg, not
O 0000122C
O 0000123C
O 00001230
O FFFFFFFC
O 00001200
O 00000230
O FFFFFFFD
O 0FFFFFFF
O FFFFFFFF
O 00012340
O 40000123
O FFFFFF8F
O FFFFEDCC
O 00000007
# Loaded word, input port, branch outputs, subroutine, link value
O 00001234
O A5A5C3C3
O 00000004
O FFFFFFF8
O 000000C0
O 00000031
S 000000B0 00001234
S 000000B4 00000007

// File: cpuTop.f
logic/cpuPkg.sv
logic/controlUnit.sv
logic/registerFile.sv
logic/aluUnit.sv
logic/instrRegs.sv
logic/memPort.sv
logic/busMux.sv
logic/cpuTop.sv
sim/cpuTopTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the cpuTop testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f cpuTop.f --top-module cpuTopTb -o cpuTopTbSim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cpuTopTbSim > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
if [ $runStatus -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi
exit 0

// File: sim/cpuTopTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTopTb;
	import cpuPkg::*;

	localparam int memWords = 256;
	localparam int settleCycles = 10;

	logic clock = 1'b0;
	logic reset;
	logic [dataWidth-1:0] memRdData;
	logic [dataWidth-1:0] inPort;
	logic [dataWidth-1:0] memAddr;
	logic [dataWidth-1:0] memWrData;
	logic memRead;
	logic memWrite;
	logic [dataWidth-1:0] outPort;
	logic outStrobe;
	logic halted;

	logic [dataWidth-1:0] image [memWords];
	logic [dataWidth-1:0] mem [memWords] = '{default: '0};
	logic [dataWidth-1:0] outExpected [$];
	logic [dataWidth-1:0] storeAddr [$];
	logic [dataWidth-1:0] storeData [$];
	logic [dataWidth-1:0] inValue = '0;
	int cycleLimit = 0;
	int numOut = 0;
	int numStore = 0;
	int outCount = 0;
	int storeCount = 0;

	always #10 clock = ~clock;

	cpuTop uut (
		.clock(clock), .reset(reset), .memRdData(memRdData), .inPort(inPort),
		.memAddr(memAddr), .memWrData(memWrData), .memRead(memRead), .memWrite(memWrite),
		.outPort(outPort), .outStrobe(outStrobe), .halted(halted)
	);

	// Read data is valid only while memRead is high
	assign memRdData = memRead ? mem[memAddr[7:0]] : '0;

	// Memory image is copied in while reset is high
	always @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < memWords; i++) begin
				mem[i[7:0]] <= image[i[7:0]];
			end
		end else if (memWrite) begin
			mem[memAddr[7:0]] <= memWrData;
		end
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string what, input logic [dataWidth-1:0] actual,
		input logic [dataWidth-1:0] expected);
		if (actual !== expected) begin
			failRun($sformatf("ERROR at %0t ns: %s is %h, expected %h",
				$time, what, actual, expected));
		end
	endtask

	task automatic readTrace();
		int fd;
		int ch;
		int got;
		int want;
		logic [7:0] tag;
		logic [dataWidth-1:0] first;
		logic [dataWidth-1:0] second;
		fd = $fopen("sim/cpuTrace.txt", "r");
		if (fd == 0) begin
			failRun("Could not open the trace file sim/cpuTrace.txt");
		end
		ch = $fgetc(fd);
		while (ch != -1) begin
			tag = ch[7:0];
			got = 0;
			want = 0;
			if (tag == "#") begin
				while (ch != -1 && ch != 10) begin
					ch = $fgetc(fd);
				end
			end else if (tag == "P") begin
				want = 2;
				got = $fscanf(fd, "%h %h", first, second);
				image[first[7:0]] = second;
			end else if (tag == "I") begin
				want = 1;
				got = $fscanf(fd, "%h", first);
				inValue = first;
			end else if (tag == "O") begin
				want = 1;
				got = $fscanf(fd, "%h", first);
				outExpected.push_back(first);
			end else if (tag == "S") begin
				want = 2;
				got = $fscanf(fd, "%h %h", first, second);
				storeAddr.push_back(first);
				storeData.push_back(second);
			end else if (tag == "L") begin
				want = 1;
				got = $fscanf(fd, "%d", first);
				cycleLimit = first;
			end else if (tag != " " && tag != "\n" && tag != "\r" && tag != "\t") begin
				failRun("The trace file holds a line with an unknown tag");
			end
			if (got != want) begin
				failRun("The trace file holds a line with missing fields");
			end
			if (ch != -1) begin
				ch = $fgetc(fd);
			end
		end
		$fclose(fd);
	endtask

	// Output and store events seen mid-cycle
	always @(negedge clock) begin
		if (!reset && outStrobe) begin
			if (outExpected.size() == 0) begin
				failRun("An output strobe came after all expected outputs were seen");
			end else begin
				checkValue("outPort", outPort, outExpected.pop_front());
				outCount++;
			end
		end
		if (!reset && memWrite) begin
			if (storeAddr.size() == 0) begin
				failRun("A memory write came after all expected stores were seen");
			end else begin
				checkValue("store address", memAddr, storeAddr.pop_front());
				checkValue("store data", memWrData, storeData.pop_front());
				storeCount++;
			end
		end
	end

	initial begin
		int cycles;
		reset = 1'b1;
		inPort = '0;
		for (int i = 0; i < memWords; i++) begin
			image[i[7:0]] = {8'hE5, i[7:0], ~i[7:0], 8'h3C};
		end
		readTrace();
		numOut = outExpected.size();
		numStore = storeAddr.size();
		@(posedge clock);
		inPort <= inValue;
		@(posedge clock);
		reset <= 1'b0;
		cycles = 0;
		while (halted !== 1'b1 && cycles < cycleLimit) begin
			@(negedge clock);
			cycles++;
		end
		if (halted !== 1'b1) begin
			failRun($sformatf("Timed out, the CPU did not halt within %0d cycles", cycleLimit));
		end
		// Stay a while to catch stray strobes after halt
		cycles = 0;
		while (cycles < settleCycles) begin
			@(negedge clock);
			cycles++;
		end
		if (outCount == numOut && storeCount == numStore) begin
			$display("Test passed");
			$finish;
		end else begin
			checkValue("output count", outCount, numOut);
			checkValue("store count", storeCount, numStore);
		end
	end

endmodule

`default_nettype wire

// File: logic/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
	input wire logic clock,
	input wire logic reset,
	input wire logic [cpuPkg::dataWidth-1:0] memRdData,
	input wire logic [cpuPkg::dataWidth-1:0] inPort,
	output logic [cpuPkg::dataWidth-1:0] memAddr,
	output logic [cpuPkg::dataWidth-1:0] memWrData,
	output logic memRead,
	output logic memWrite,
	output logic [cpuPkg::dataWidth-1:0] outPort,
	output logic outStrobe,
	output logic halted
);
	import cpuPkg::*;

	ctrlSignals_t ctrl;
	instrWord_u ir;
	logic conFlag;
	logic [dataWidth-1:0] bus;
	logic [dataWidth-1:0] regOut;
	logic [dataWidth-1:0] zOutValue;
	logic [dataWidth-1:0] pcValue;
	logic [dataWidth-1:0] mdrValue;
	logic [dataWidth-1:0] cseValue;
	logic [dataWidth-1:0] inPortValue;

	controlUnit control (
		.clock(clock), .reset(reset), .ir(ir), .conFlag(conFlag),
		.ctrl(ctrl), .halted(halted)
	);

	registerFile regFile (
		.clock(clock), .reset(reset), .ctrl(ctrl), .ir(ir), .bus(bus), .regOut(regOut)
	);

	aluUnit alu (
		.clock(clock), .reset(reset), .ctrl(ctrl), .bus(bus), .zOutValue(zOutValue)
	);

	instrRegs instr (
		.clock(clock), .reset(reset), .ctrl(ctrl), .bus(bus), .ir(ir),
		.pcValue(pcValue), .cseValue(cseValue), .conFlag(conFlag)
	);

	memPort mem (
		.clock(clock), .reset(reset), .ctrl(ctrl), .bus(bus),
		.memRdData(memRdData), .inPort(inPort),
		.memAddr(memAddr), .memWrData(memWrData),
		.memRead(memRead), .memWrite(memWrite),
		.mdrValue(mdrValue), .inPortValue(inPortValue),
		.outPort(outPort), .outStrobe(outStrobe)
	);

	busMux mux (
		.ctrl(ctrl), .regOut(regOut), .zOutValue(zOutValue), .pcValue(pcValue),
		.mdrValue(mdrValue), .cseValue(cseValue), .inPortValue(inPortValue), .bus(bus)
	);

endmodule

`default_nettype wire

// File: logic/busMux.sv
`timescale 1ns/1ps
`default_nettype none

module busMux (
	input wire cpuPkg::ctrlSignals_t ctrl,
	input wire logic [cpuPkg::dataWidth-1:0] regOut,
	input wire logic [cpuPkg::dataWidth-1:0] zOutValue,
	input wire logic [cpuPkg::dataWidth-1:0] pcValue,
	input wire logic [cpuPkg::dataWidth-1:0] mdrValue,
	input wire logic [cpuPkg::dataWidth-1:0] cseValue,
	input wire logic [cpuPkg::dataWidth-1:0] inPortValue,
	output logic [cpuPkg::dataWidth-1:0] bus
);
	import cpuPkg::*;

	logic regDrive;
	logic [5:0] enables;

	assign regDrive = ctrl.rout || ctrl.baOut;
	assign enables = {regDrive, ctrl.zOut, ctrl.pcOut, ctrl.mdrOut, ctrl.cseOut, ctrl.inPortOut};

	always_comb begin
		bus = '0;
		if (regDrive) bus = regOut;
		else if (ctrl.zOut) bus = zOutValue;
		else if (ctrl.pcOut) bus = pcValue;
		else if (ctrl.mdrOut) bus = mdrValue;
		else if (ctrl.cseOut) bus = cseValue;
		else if (ctrl.inPortOut) bus = inPortValue;
	end

	// No clock here, so checked once the inputs settle
	always_comb begin
		singleDriver: assert final ($onehot0(enables));
	end

endmodule

`default_nettype wire

// File: logic/memPort.sv
`timescale 1ns/1ps
`default_nettype none

module memPort (
	input wire logic clock,
	input wire logic reset,
	input wire cpuPkg::ctrlSignals_t ctrl,
	input wire logic [cpuPkg::dataWidth-1:0] bus,
	input wire logic [cpuPkg::dataWidth-1:0] memRdData,
	input wire logic [cpuPkg::dataWidth-1:0] inPort,
	output logic [cpuPkg::dataWidth-1:0] memAddr,
	output logic [cpuPkg::dataWidth-1:0] memWrData,
	output logic memRead,
	output logic memWrite,
	output logic [cpuPkg::dataWidth-1:0] mdrValue,
	output logic [cpuPkg::dataWidth-1:0] inPortValue,
	output logic [cpuPkg::dataWidth-1:0] outPort,
	output logic outStrobe
);
	import cpuPkg::*;

	assign memRead = ctrl.memRead;
	assign memWrite = ctrl.memWrite;
	assign memWrData = mdrValue;

	always_ff @(posedge clock) begin
		if (reset) begin
			memAddr <= '0;
			mdrValue <= '0;
			outPort <= '0;
			outStrobe <= 1'b0;
			inPortValue <= '0;
		end else begin
			if (ctrl.marIn) memAddr <= bus;
			if (ctrl.mdrIn) mdrValue <= ctrl.memRead ? memRdData : bus;
			if (ctrl.outPortIn) outPort <= bus;
			outStrobe <= ctrl.outPortIn;
			inPortValue <= inPort;
		end
	end

	noReadWrite: assert property (@(posedge clock) disable iff (reset)
		!(memRead && memWrite));

endmodule

`default_nettype wire

// File: logic/instrRegs.sv
`timescale 1ns/1ps
`default_nettype none

module instrRegs (
	input wire logic clock,
	input wire logic reset,
	input wire cpuPkg::ctrlSignals_t ctrl,
	input wire logic [cpuPkg::dataWidth-1:0] bus,
	output cpuPkg::instrWord_u ir,
	output logic [cpuPkg::dataWidth-1:0] pcValue,
	output logic [cpuPkg::dataWidth-1:0] cseValue,
	output logic conFlag
);
	import cpuPkg::*;

	logic condMet;

	assign cseValue = {{(dataWidth-immWidth){ir.immForm.imm[immWidth-1]}}, ir.immForm.imm};

	always_comb begin
		case (ir.branchForm.cond)
			condZero: condMet = (bus == '0);
			condNonZero: condMet = (bus != '0);
			condPositive: condMet = !bus[dataWidth-1] && (bus != '0);
			default: condMet = bus[dataWidth-1];
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pcValue <= '0;
			ir <= '0;
			conFlag <= 1'b0;
		end else begin
			if (ctrl.pcIn) pcValue <= bus;
			if (ctrl.irIn) ir <= bus;
			if (ctrl.conIn) conFlag <= condMet;
		end
	end

endmodule

`default_nettype wire

// File: logic/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
	input wire logic clock,
	input wire logic reset,
	input wire cpuPkg::ctrlSignals_t ctrl,
	input wire logic [cpuPkg::dataWidth-1:0] bus,
	output logic [cpuPkg::dataWidth-1:0] zOutValue
);
	import cpuPkg::*;

	logic [dataWidth-1:0] y;
	logic [dataWidth-1:0] z;
	logic [dataWidth-1:0] result;
	logic [4:0] count;
	logic [2*dataWidth-1:0] rotRight;
	logic [2*dataWidth-1:0] rotLeft;

	assign count = bus[4:0];
	// Rotates from a doubled word
	assign rotRight = {y, y} >> count;
	assign rotLeft = {y, y} << count;

	always_comb begin
		result = '0;
		if (ctrl.aluOp.add) result = y + bus;
		else if (ctrl.aluOp.sub) result = y - bus;
		else if (ctrl.aluOp.andOp) result = y & bus;
		else if (ctrl.aluOp.orOp) result = y | bus;
		else if (ctrl.aluOp.shr) result = y >> count;
		else if (ctrl.aluOp.shra) result = $signed(y) >>> count;
		else if (ctrl.aluOp.shl) result = y << count;
		else if (ctrl.aluOp.ror) result = rotRight[dataWidth-1:0];
		else if (ctrl.aluOp.rol) result = rotLeft[2*dataWidth-1:dataWidth];
		else if (ctrl.aluOp.neg) result = -bus;
		else if (ctrl.aluOp.notOp) result = ~bus;
		else if (ctrl.aluOp.incPc) result = bus + 1'b1;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			y <= '0;
			z <= '0;
		end else begin
			if (ctrl.yIn) y <= bus;
			if (ctrl.zIn) z <= result;
		end
	end

	assign zOutValue = z;

endmodule

`default_nettype wire

// File: logic/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input wire logic clock,
	input wire logic reset,
	input wire cpuPkg::ctrlSignals_t ctrl,
	input wire cpuPkg::instrWord_u ir,
	input wire logic [cpuPkg::dataWidth-1:0] bus,
	output logic [cpuPkg::dataWidth-1:0] regOut
);
	import cpuPkg::*;

	logic [dataWidth-1:0] regs [numRegs];
	logic [regAddrWidth-1:0] sel;

	always_comb begin
		sel = '0;
		if (ctrl.gra) sel = ir.regForm.ra;
		else if (ctrl.grb) sel = ir.regForm.rb;
		else if (ctrl.grc) sel = ir.regForm.rc;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < numRegs; i++) regs[i] <= '0;
		end else if (ctrl.rin) begin
			regs[sel] <= bus;
		end
	end

	// R0 is a zero base
	assign regOut = (ctrl.rout || (ctrl.baOut && sel != '0)) ? regs[sel] : '0;

	oneRegSelect: assert property (@(posedge clock) disable iff (reset)
		$onehot0({ctrl.gra, ctrl.grb, ctrl.grc}));

endmodule

`default_nettype wire

// File: logic/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input wire logic clock,
	input wire logic reset,
	input wire cpuPkg::instrWord_u ir,
	input wire logic conFlag,
	output cpuPkg::ctrlSignals_t ctrl,
	output logic halted
);
	import cpuPkg::*;

	logic [stepWidth-1:0] step;
	logic [stepWidth-1:0] firstStep;
	logic [stepWidth-1:0] curStep;
	logic [opcodeWidth-1:0] stepOp;
	logic lastStep;
	logic knownStep;

	// IR holds the new instruction once T2 has ended
	always_comb begin
		case (ir.regForm.opcode)
			opLd, opLdi, opSt, opAdd, opSub, opShr, opShra, opShl, opRor,
			opRol, opAnd, opOr, opAddi, opAndi, opOri, opNeg, opNot, opBr,
			opJr, opJal, opIn, opOut, opNop, opHalt:
				firstStep = {ir.regForm.opcode, idx3};
			// Unknown opcodes run as NOP
			default: firstStep = stepNop;
		endcase
	end

	assign curStep = (step == stepDecode) ? firstStep : step;
	assign stepOp = curStep[stepWidth-1:3];
	assign halted = (curStep == stepHalt);

	always_ff @(posedge clock) begin
		if (reset) begin
			step <= stepReset;
		end else begin
			case (curStep)
				stepReset: step <= stepT0;
				stepT0: step <= stepT1;
				stepT1: step <= stepT2;
				stepT2: step <= stepDecode;
				stepHalt: step <= stepHalt;
				default: step <= lastStep ? stepT0 : curStep + 1'b1;
			endcase
		end
	end

	always_comb begin
		ctrl = '0;
		lastStep = 1'b0;
		knownStep = 1'b1;
		case (curStep)
			stepReset: ;
			stepT0: begin
				ctrl.pcOut = 1'b1;
				ctrl.marIn = 1'b1;
				ctrl.aluOp.incPc = 1'b1;
				ctrl.zIn = 1'b1;
			end
			stepT1: begin
				ctrl.zOut = 1'b1;
				ctrl.pcIn = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.mdrIn = 1'b1;
			end
			stepT2: begin
				ctrl.mdrOut = 1'b1;
				ctrl.irIn = 1'b1;
			end
			// Base address plus constant
			{opLd, idx3}, {opLdi, idx3}, {opSt, idx3}: begin
				ctrl.grb = 1'b1;
				ctrl.baOut = 1'b1;
				ctrl.yIn = 1'b1;
			end
			{opLd, idx4}, {opLdi, idx4}, {opSt, idx4}, {opBr, idx5}: begin
				ctrl.cseOut = 1'b1;
				ctrl.aluOp.add = 1'b1;
				ctrl.zIn = 1'b1;
			end
			{opLd, idx5}, {opSt, idx5}: begin
				ctrl.zOut = 1'b1;
				ctrl.marIn = 1'b1;
			end
			{opLd, idx6}: begin
				ctrl.memRead = 1'b1;
				ctrl.mdrIn = 1'b1;
			end
			{opLd, idx7}: begin
				ctrl.mdrOut = 1'b1;
				ctrl.gra = 1'b1;
				ctrl.rin = 1'b1;
				lastStep = 1'b1;
			end
			{opSt, idx6}: begin
				ctrl.gra = 1'b1;
				ctrl.rout = 1'b1;
				ctrl.mdrIn = 1'b1;
			end
			{opSt, idx7}: begin
				ctrl.memWrite = 1'b1;
				lastStep = 1'b1;
			end
			{opAdd, idx3}, {opSub, idx3}, {opShr, idx3}, {opShra, idx3}, {opShl, idx3},
			{opRor, idx3}, {opRol, idx3}, {opAnd, idx3}, {opOr, idx3}, {opAddi, idx3},
			{opAndi, idx3}, {opOri, idx3}: begin
				ctrl.grb = 1'b1;
				ctrl.rout = 1'b1;
				ctrl.yIn = 1'b1;
			end
			{opAdd, idx4}, {opSub, idx4}, {opShr, idx4}, {opShra, idx4}, {opShl, idx4},
			{opRor, idx4}, {opRol, idx4}, {opAnd, idx4}, {opOr, idx4}, {opAddi, idx4},
			{opAndi, idx4}, {opOri, idx4}: begin
				// Immediate forms take the constant instead of rc
				if (stepOp == opAddi || stepOp == opAndi || stepOp == opOri) begin
					ctrl.cseOut = 1'b1;
				end else begin
					ctrl.grc = 1'b1;
					ctrl.rout = 1'b1;
				end
				ctrl.zIn = 1'b1;
				ctrl.aluOp.add = (stepOp == opAdd) || (stepOp == opAddi);
				ctrl.aluOp.sub = (stepOp == opSub);
				ctrl.aluOp.andOp = (stepOp == opAnd) || (stepOp == opAndi);
				ctrl.aluOp.orOp = (stepOp == opOr) || (stepOp == opOri);
				ctrl.aluOp.shr = (stepOp == opShr);
				ctrl.aluOp.shra = (stepOp == opShra);
				ctrl.aluOp.shl = (stepOp == opShl);
				ctrl.aluOp.ror = (stepOp == opRor);
				ctrl.aluOp.rol = (stepOp == opRol);
			end
			{opNeg, idx3}, {opNot, idx3}: begin
				ctrl.grb = 1'b1;
				ctrl.rout = 1'b1;
				ctrl.aluOp.neg = (stepOp == opNeg);
				ctrl.aluOp.notOp = (stepOp == opNot);
				ctrl.zIn = 1'b1;
			end
			{opLdi, idx5}, {opAdd, idx5}, {opSub, idx5}, {opShr, idx5}, {opShra, idx5},
			{opShl, idx5}, {opRor, idx5}, {opRol, idx5}, {opAnd, idx5}, {opOr, idx5},
			{opAddi, idx5}, {opAndi, idx5}, {opOri, idx5}, {opNeg, idx4}, {opNot, idx4}: begin
				ctrl.zOut = 1'b1;
				ctrl.gra = 1'b1;
				ctrl.rin = 1'b1;
				lastStep = 1'b1;
			end
			{opBr, idx3}: begin
				ctrl.gra = 1'b1;
				ctrl.rout = 1'b1;
				ctrl.conIn = 1'b1;
			end
			{opBr, idx4}: begin
				ctrl.pcOut = 1'b1;
				ctrl.yIn = 1'b1;
			end
			{opBr, idx6}: begin
				ctrl.zOut = 1'b1;
				ctrl.pcIn = conFlag;
				lastStep = 1'b1;
			end
			// Link register is rb
			{opJal, idx3}: begin
				ctrl.pcOut = 1'b1;
				ctrl.grb = 1'b1;
				ctrl.rin = 1'b1;
			end
			{opJr, idx3}, {opJal, idx4}: begin
				ctrl.gra = 1'b1;
				ctrl.rout = 1'b1;
				ctrl.pcIn = 1'b1;
				lastStep = 1'b1;
			end
			{opIn, idx3}: begin
				ctrl.inPortOut = 1'b1;
				ctrl.gra = 1'b1;
				ctrl.rin = 1'b1;
				lastStep = 1'b1;
			end
			{opOut, idx3}: begin
				ctrl.gra = 1'b1;
				ctrl.rout = 1'b1;
				ctrl.outPortIn = 1'b1;
				lastStep = 1'b1;
			end
			stepNop: lastStep = 1'b1;
			stepHalt: ;
			default: knownStep = 1'b0;
		endcase
	end

	stepDefined: assert property (@(posedge clock) disable iff (reset) knownStep);

endmodule

`default_nettype wire

// File: logic/cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 4;
	localparam int numRegs = 16;
	localparam int opcodeWidth = 5;
	localparam int stepWidth = 8;
	localparam int immWidth = 19;

	// Opcode numbering
	localparam logic [opcodeWidth-1:0] opLd = 5'd0;
	localparam logic [opcodeWidth-1:0] opLdi = 5'd1;
	localparam logic [opcodeWidth-1:0] opSt = 5'd2;
	localparam logic [opcodeWidth-1:0] opAdd = 5'd3;
	localparam logic [opcodeWidth-1:0] opSub = 5'd4;
	localparam logic [opcodeWidth-1:0] opShr = 5'd5;
	localparam logic [opcodeWidth-1:0] opShra = 5'd6;
	localparam logic [opcodeWidth-1:0] opShl = 5'd7;
	localparam logic [opcodeWidth-1:0] opRor = 5'd8;
	localparam logic [opcodeWidth-1:0] opRol = 5'd9;
	localparam logic [opcodeWidth-1:0] opAnd = 5'd10;
	localparam logic [opcodeWidth-1:0] opOr = 5'd11;
	localparam logic [opcodeWidth-1:0] opAddi = 5'd12;
	localparam logic [opcodeWidth-1:0] opAndi = 5'd13;
	localparam logic [opcodeWidth-1:0] opOri = 5'd14;
	localparam logic [opcodeWidth-1:0] opNeg = 5'd17;
	localparam logic [opcodeWidth-1:0] opNot = 5'd18;
	localparam logic [opcodeWidth-1:0] opBr = 5'd19;
	localparam logic [opcodeWidth-1:0] opJr = 5'd20;
	localparam logic [opcodeWidth-1:0] opJal = 5'd21;
	localparam logic [opcodeWidth-1:0] opIn = 5'd22;
	localparam logic [opcodeWidth-1:0] opOut = 5'd23;
	localparam logic [opcodeWidth-1:0] opNop = 5'd26;
	localparam logic [opcodeWidth-1:0] opHalt = 5'd27;

	// Instruction steps are opcode then index 3..7
	localparam logic [stepWidth-1:0] stepReset = 8'b00000000;
	localparam logic [stepWidth-1:0] stepT0 = 8'b11111000;
	localparam logic [stepWidth-1:0] stepT1 = 8'b11111001;
	localparam logic [stepWidth-1:0] stepT2 = 8'b11111010;
	// First instruction step, resolved from the freshly loaded IR
	localparam logic [stepWidth-1:0] stepDecode = 8'b11111011;
	localparam logic [2:0] idx3 = 3'd3;
	localparam logic [2:0] idx4 = 3'd4;
	localparam logic [2:0] idx5 = 3'd5;
	localparam logic [2:0] idx6 = 3'd6;
	localparam logic [2:0] idx7 = 3'd7;
	localparam logic [stepWidth-1:0] stepNop = {opNop, idx3};
	localparam logic [stepWidth-1:0] stepHalt = {opHalt, idx3};

	localparam logic [1:0] condZero = 2'b00;
	localparam logic [1:0] condNonZero = 2'b01;
	localparam logic [1:0] condPositive = 2'b10;
	localparam logic [1:0] condNegative = 2'b11;

	typedef union packed {
		struct packed {
			logic [opcodeWidth-1:0] opcode;
			logic [regAddrWidth-1:0] ra;
			logic [regAddrWidth-1:0] rb;
			logic [regAddrWidth-1:0] rc;
			logic [14:0] unused;
		} regForm;
		struct packed {
			logic [opcodeWidth-1:0] opcode;
			logic [regAddrWidth-1:0] ra;
			logic [regAddrWidth-1:0] rb;
			logic [immWidth-1:0] imm;
		} immForm;
		struct packed {
			logic [opcodeWidth-1:0] opcode;
			logic [regAddrWidth-1:0] ra;
			logic [1:0] pad;
			logic [1:0] cond;
			logic [immWidth-1:0] imm;
		} branchForm;
	} instrWord_u;

	typedef struct packed {
		logic add;
		logic sub;
		logic andOp;
		logic orOp;
		logic shr;
		logic shra;
		logic shl;
		logic ror;
		logic rol;
		logic neg;
		logic notOp;
		logic incPc;
	} aluOp_t;

	typedef struct packed {
		logic gra;
		logic grb;
		logic grc;
		logic rin;
		logic rout;
		logic baOut;
		logic yIn;
		logic zIn;
		logic pcIn;
		logic irIn;
		logic marIn;
		logic mdrIn;
		logic conIn;
		logic outPortIn;
		logic zOut;
		logic pcOut;
		logic mdrOut;
		logic cseOut;
		logic inPortOut;
		logic memRead;
		logic memWrite;
		aluOp_t aluOp;
	} ctrlSignals_t;

endpackage

`default_nettype wire
